/* design/host_msg_pkg.sv */
`default_nettype none

package host_msg_pkg;

  localparam int XB_SIZE   = 32;  // host link word
  localparam int CMD_WORDS = 3;   // words per command

  // declared msb first, so exposure sits in the third word
  typedef struct packed {
    logic [31:0] exposure;          // carried, not used
    logic [7:0]  stride;
    logic [23:0] clocks_per_frame;
    logic [23:0] n_frame;
    logic        spare_7;
    logic        start;             // 0 = stop
    logic [4:0]  spare_1;
    logic        is_data;           // header type, 0 = control
  } host_cmd_t;

  // one report word back to the host
  typedef struct packed {
    logic [7:0]  frame;             // low bits of frame number
    logic [7:0]  zmw;
    logic [15:0] value;
  } fpga_report_t;

endpackage

`default_nettype wire

/* design/pulse_ram_pkg.sv */
`default_nettype none

package pulse_ram_pkg;

  localparam int N_ZMW           = 128;
  localparam int ZMW_W           = 7;
  localparam int RAM_DATA_W      = 16;
  localparam int BRAM_READ_DELAY = 3;
  localparam int FIFO_DEPTH      = 16;
  localparam int TOKEN_W         = 1 + ZMW_W + RAM_DATA_W;

  typedef struct packed {
    logic [TOKEN_W-4:0] pad;
    logic               write;    // 1 = write pass, 0 = read pass
    logic               sof;      // 0 = eof
    logic               is_data;
  } token_ctrl_t;

  typedef struct packed {
    logic [RAM_DATA_W-1:0] value;
    logic [ZMW_W-1:0]      zmw;
    logic                  is_data;
  } token_data_t;

  // bit 0 tells which view applies
  typedef union packed {
    token_ctrl_t ctrl;
    token_data_t data;
  } ram_token_u;

  typedef struct packed {
    logic [ZMW_W-1:0]      zmw;
    logic [RAM_DATA_W-1:0] value;
  } readback_t;

  // the code is what the LED shows
  typedef enum logic [3:0] {
    ERROR      = 4'd0,
    STOPPED    = 4'd1,
    WRITE_SOF  = 4'd2,
    WRITE      = 4'd3,
    WRITE_EOF  = 4'd4,
    READ_SOF   = 4'd5,
    READING    = 4'd6,
    INTERFRAME = 4'd7,
    STOPPING   = 4'd8
  } pacer_state_e;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_WRITING,
    CTRL_READING,
    CTRL_THROTTLED,
    CTRL_FINISHING_RD
  } ctrl_state_e;

endpackage

`default_nettype wire

/* design/token_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module token_fifo #(
  parameter int WIDTH = 24,
  parameter int DEPTH = 16
) (
  input  wire              CLK,
  input  wire              RESET,
  input  wire  [WIDTH-1:0] din,
  input  wire              wren,
  input  wire              rden,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             almost_full,
  output logic             empty,
  output logic             almost_empty
);

  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       do_wr;
  logic                       do_rd;

  assign do_wr = wren && !full;     // writes to a full FIFO are dropped
  assign do_rd = rden && !empty;

  assign dout         = mem[rd_ptr];  // show-ahead head
  assign full         = count == DEPTH;
  assign almost_full  = count >= DEPTH - 4;
  assign empty        = count == 0;
  assign almost_empty = count == 1;

  always_ff @(posedge CLK) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/pulse_list_bram.sv */
`timescale 1ns/1ps
`default_nettype none

module pulse_list_bram
  import pulse_ram_pkg::*;
(
  input  wire                   CLK,
  input  wire  [ZMW_W-1:0]      addr,
  input  wire  [RAM_DATA_W-1:0] din,
  input  wire                   wren,
  output logic [RAM_DATA_W-1:0] dout
);

  logic [RAM_DATA_W-1:0] mem [N_ZMW];
  logic [RAM_DATA_W-1:0] rd_pipe [BRAM_READ_DELAY];  // output registers

  always_ff @(posedge CLK) begin
    if (wren) mem[addr] <= din;
  end

  // read-first; data leaves the last stage three cycles after addr
  always_ff @(posedge CLK) begin
    rd_pipe[0] <= mem[addr];
    for (int i = 1; i < BRAM_READ_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[BRAM_READ_DELAY-1];

endmodule

`default_nettype wire

/* design/msg_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_assembler
  import host_msg_pkg::*;
(
  input  wire                CLK,
  input  wire                RESET,
  input  wire                pc_msg_valid,
  input  wire  [XB_SIZE-1:0] pc_msg,
  output logic               cmd_valid,
  output host_cmd_t          cmd
);

  logic [1:0]                         word_idx;  // next word slot
  logic [(CMD_WORDS-1)*XB_SIZE-1:0]   cache;     // first two words
  logic                               last_word;

  assign last_word = word_idx == 2'(CMD_WORDS - 1);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      word_idx  <= '0;  // realign to word one
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (pc_msg_valid) begin
        if (last_word) begin
          word_idx  <= '0;
          cmd_valid <= 1'b1;
        end else begin
          word_idx <= word_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (pc_msg_valid) begin
      if (last_word) cmd <= {pc_msg, cache};  // third word on top
      else cache[word_idx*XB_SIZE +: XB_SIZE] <= pc_msg;
    end
  end

endmodule

`default_nettype wire

/* design/frame_pacer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_pacer
  import host_msg_pkg::*;
  import pulse_ram_pkg::*;
(
  input  wire            CLK,
  input  wire            RESET,
  input  wire            cmd_valid,
  input  wire host_cmd_t cmd,
  output ram_token_u     tok_din,
  output logic           tok_wren,
  input  wire            tok_full,
  input  wire readback_t rb_dout,
  input  wire            rb_empty,
  output logic           rb_rden,
  input  wire            ctrl_busy,
  output logic           fpga_msg_valid,
  output fpga_report_t   fpga_msg,
  output logic           app_running,
  output logic           app_error,
  output logic [3:0]     gpio_led
);

  pacer_state_e          state;
  logic [23:0]           frames_max;
  logic [23:0]           clocks_max;
  logic [7:0]            stride;
  logic [ZMW_W-1:0]      zmw_cnt;     // write pass index
  logic [RAM_DATA_W-1:0] wr_value;    // zmw_cnt * stride
  logic [23:0]           frame_cnt;
  logic [ZMW_W-1:0]      report_cnt;  // reports in this frame
  logic [23:0]           clk_cnt;     // interframe gap
  logic                  eof_pending;
  logic                  is_data_msg;
  logic                  is_start;
  logic                  is_stop;
  logic                  active;

  assign is_data_msg = cmd_valid && cmd.is_data;
  assign is_start    = cmd_valid && !cmd.is_data && cmd.start;
  assign is_stop     = cmd_valid && !cmd.is_data && !cmd.start;
  assign active      = state inside {WRITE_SOF, WRITE, WRITE_EOF, READ_SOF, READING,
                                     INTERFRAME};

  assign rb_rden     = !rb_empty;  // always drain, reports only in READING
  assign app_running = state != STOPPED && state != ERROR;
  assign app_error   = state == ERROR;
  assign gpio_led    = state;

  always_comb begin
    tok_din  = '0;  // all zero is an eof token
    tok_wren = 1'b0;
    case (state)
      WRITE_SOF: begin
        tok_din.ctrl.sof   = 1'b1;
        tok_din.ctrl.write = 1'b1;
        tok_wren           = !tok_full;
      end
      WRITE: begin
        tok_din.data.is_data = 1'b1;
        tok_din.data.zmw     = zmw_cnt;
        tok_din.data.value   = wr_value;
        tok_wren             = !tok_full;
      end
      WRITE_EOF: tok_wren = !tok_full;
      READ_SOF: begin
        tok_din.ctrl.sof = 1'b1;
        tok_wren         = !tok_full;
      end
      STOPPING: tok_wren = eof_pending && !tok_full;
      default:  tok_wren = 1'b0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state          <= STOPPED;
      eof_pending    <= 1'b0;
      fpga_msg_valid <= 1'b0;
      zmw_cnt        <= '0;
      wr_value       <= '0;
      frame_cnt      <= '0;
      report_cnt     <= '0;
      clk_cnt        <= '0;
    end else begin
      fpga_msg_valid <= rb_rden && state == READING;
      if (is_data_msg) begin
        state <= ERROR;  // sticky
      end else if (is_stop && active) begin
        state       <= STOPPING;
        eof_pending <= 1'b1;
      end else begin
        case (state)
          STOPPED: if (is_start) begin
            frames_max <= cmd.n_frame;
            clocks_max <= cmd.clocks_per_frame;
            stride     <= cmd.stride;
            zmw_cnt    <= '0;
            wr_value   <= '0;
            frame_cnt  <= '0;
            state      <= WRITE_SOF;
          end
          WRITE_SOF: if (!tok_full) state <= WRITE;
          WRITE: if (!tok_full) begin
            zmw_cnt  <= zmw_cnt + 1'b1;
            wr_value <= wr_value + RAM_DATA_W'(stride);
            if (zmw_cnt == ZMW_W'(N_ZMW - 1)) state <= WRITE_EOF;
          end
          WRITE_EOF: if (!tok_full) state <= (frames_max == '0) ? STOPPED : READ_SOF;
          READ_SOF: if (!tok_full) begin
            report_cnt <= '0;
            state      <= READING;
          end
          READING: if (rb_rden) begin
            report_cnt <= report_cnt + 1'b1;
            if (report_cnt == ZMW_W'(N_ZMW - 1)) begin  // last report of frame
              frame_cnt <= frame_cnt + 1'b1;
              clk_cnt   <= '0;
              state     <= (frame_cnt + 24'd1 == frames_max) ? STOPPED : INTERFRAME;
            end
          end
          INTERFRAME: begin
            if (clk_cnt + 24'd1 >= clocks_max) state <= READ_SOF;
            else clk_cnt <= clk_cnt + 1'b1;
          end
          STOPPING: begin
            if (!tok_full) eof_pending <= 1'b0;
            // wait for the read pipe to empty out
            if (!eof_pending && !ctrl_busy && rb_empty) state <= STOPPED;
          end
          default: state <= state;  // ERROR until reset
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    fpga_msg.frame <= frame_cnt[7:0];
    fpga_msg.zmw   <= {1'b0, rb_dout.zmw};
    fpga_msg.value <= rb_dout.value;
  end

endmodule

`default_nettype wire

/* design/pulse_list_ram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pulse_list_ram_ctrl
  import pulse_ram_pkg::*;
(
  input  wire                   CLK,
  input  wire                   RESET,
  input  wire ram_token_u       tok,
  input  wire                   tok_empty,
  output logic                  tok_rden,
  output logic [ZMW_W-1:0]      ram_addr,
  output logic [RAM_DATA_W-1:0] ram_din,
  output logic                  ram_wren,
  input  wire  [RAM_DATA_W-1:0] ram_dout,
  output readback_t             rb_din,
  output logic                  rb_wren,
  input  wire                   rb_almost_full,
  output logic                  busy
);

  ctrl_state_e                state;
  logic [ZMW_W-1:0]           rd_idx;    // next address to read
  logic                       rd_issue;  // ram_addr holds a read this cycle
  logic [BRAM_READ_DELAY-1:0] tag_vld;
  logic [ZMW_W-1:0]           tag_idx [BRAM_READ_DELAY];
  logic                       tok_is_sof;
  logic                       tok_is_eof;

  assign tok_is_sof = !tok_empty && !tok.ctrl.is_data && tok.ctrl.sof;
  assign tok_is_eof = !tok_empty && !tok.ctrl.is_data && !tok.ctrl.sof;

  always_comb begin
    case (state)
      CTRL_IDLE, CTRL_WRITING:      tok_rden = !tok_empty;
      CTRL_READING, CTRL_THROTTLED: tok_rden = tok_is_eof;  // only a stop gets through
      default:                      tok_rden = 1'b0;
    endcase
  end

  // last tag stage lines up with the BRAM output
  assign rb_wren = tag_vld[BRAM_READ_DELAY-1];
  assign rb_din  = {tag_idx[BRAM_READ_DELAY-1], ram_dout};
  assign busy    = state != CTRL_IDLE;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state    <= CTRL_IDLE;
      rd_idx   <= '0;
      rd_issue <= 1'b0;
      ram_wren <= 1'b0;
      tag_vld  <= '0;
    end else begin
      ram_wren <= 1'b0;
      rd_issue <= 1'b0;
      tag_vld  <= {tag_vld[BRAM_READ_DELAY-2:0], rd_issue};
      case (state)
        CTRL_IDLE: if (tok_is_sof) begin
          rd_idx <= '0;
          state  <= tok.ctrl.write ? CTRL_WRITING : CTRL_READING;
        end
        CTRL_WRITING: if (!tok_empty) begin
          if (tok.data.is_data) ram_wren <= 1'b1;
          else if (!tok.ctrl.sof) state <= CTRL_IDLE;  // eof ends it and a repeated sof is ignored
        end
        CTRL_READING: begin
          if (tok_is_eof) begin
            state <= CTRL_FINISHING_RD;
          end else if (rb_almost_full) begin
            state <= CTRL_THROTTLED;
          end else begin
            rd_issue <= 1'b1;
            rd_idx   <= rd_idx + 1'b1;
            if (rd_idx == ZMW_W'(N_ZMW - 1)) state <= CTRL_FINISHING_RD;
          end
        end
        CTRL_THROTTLED: begin
          if (tok_is_eof) state <= CTRL_FINISHING_RD;
          else if (!rb_almost_full) state <= CTRL_READING;
        end
        CTRL_FINISHING_RD: if (!rd_issue && tag_vld == '0) state <= CTRL_IDLE;
        default: state <= CTRL_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == CTRL_WRITING) begin
      ram_addr <= tok.data.zmw;
      ram_din  <= tok.data.value;
    end else begin
      ram_addr <= rd_idx;  // qualified by rd_issue
    end
    tag_idx[0] <= ram_addr;
    for (int i = 1; i < BRAM_READ_DELAY; i++) begin
      tag_idx[i] <= tag_idx[i-1];
    end
  end

endmodule

`default_nettype wire

/* design/application.sv */
`timescale 1ns/1ps
`default_nettype none

module application
  import host_msg_pkg::*;
  import pulse_ram_pkg::*;
(
  input  wire                CLK,
  input  wire                RESET,
  input  wire                pc_msg_valid,
  input  wire  [XB_SIZE-1:0] pc_msg,
  output logic               fpga_msg_valid,
  output fpga_report_t       fpga_msg,
  output logic               app_running,
  output logic               app_error,
  output logic [3:0]         gpio_led
);

  logic                  cmd_valid;
  host_cmd_t             cmd;
  ram_token_u            tok_din;
  ram_token_u            tok_dout;
  logic                  tok_wren;
  logic                  tok_full;
  logic                  tok_empty;
  logic                  tok_rden;
  readback_t             rb_din;
  readback_t             rb_dout;
  logic                  rb_wren;
  logic                  rb_rden;
  logic                  rb_empty;
  logic                  rb_almost_full;
  logic [ZMW_W-1:0]      ram_addr;
  logic [RAM_DATA_W-1:0] ram_din;
  logic [RAM_DATA_W-1:0] ram_dout;
  logic                  ram_wren;
  logic                  ctrl_busy;

  msg_assembler assembler_i (
    .CLK, .RESET, .pc_msg_valid, .pc_msg, .cmd_valid, .cmd
  );

  frame_pacer pacer_i (
    .CLK, .RESET, .cmd_valid, .cmd,
    .tok_din, .tok_wren, .tok_full,
    .rb_dout, .rb_empty, .rb_rden, .ctrl_busy,
    .fpga_msg_valid, .fpga_msg, .app_running, .app_error, .gpio_led
  );

  // pacer to controller
  token_fifo #(.WIDTH(TOKEN_W), .DEPTH(FIFO_DEPTH)) to_ram_fifo (
    .CLK, .RESET, .din(tok_din), .wren(tok_wren), .rden(tok_rden),
    .dout(tok_dout), .full(tok_full), .almost_full(), .empty(tok_empty),
    .almost_empty()
  );

  pulse_list_ram_ctrl ram_ctrl_i (
    .CLK, .RESET, .tok(tok_dout), .tok_empty, .tok_rden,
    .ram_addr, .ram_din, .ram_wren, .ram_dout,
    .rb_din, .rb_wren, .rb_almost_full, .busy(ctrl_busy)
  );

  pulse_list_bram bram_i (
    .CLK, .addr(ram_addr), .din(ram_din), .wren(ram_wren), .dout(ram_dout)
  );

  // readbacks to pacer, almost_full throttles the controller
  token_fifo #(.WIDTH($bits(readback_t)), .DEPTH(FIFO_DEPTH)) from_ram_fifo (
    .CLK, .RESET, .din(rb_din), .wren(rb_wren), .rden(rb_rden),
    .dout(rb_dout), .full(), .almost_full(rb_almost_full), .empty(rb_empty),
    .almost_empty()
  );

endmodule

`default_nettype wire

/* tb/tb_application.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_application
  import host_msg_pkg::*;
  import pulse_ram_pkg::*;
();

  localparam int          NUM_ROWS     = 7;
  localparam int          WAIT_LIMIT   = 20000;       // cycles allowed per wait
  localparam int          QUIET_CYCLES = 40;          // window for stray reports
  localparam int          STOP_SLACK   = FIFO_DEPTH;  // reports still in flight at a stop
  localparam logic [31:0] LFSR_SEED    = 32'h3f36;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  localparam logic [1:0] KIND_START = 2'd0;
  localparam logic [1:0] KIND_STOP  = 2'd1;
  localparam logic [1:0] KIND_DATA  = 2'd2;

  typedef struct packed {
    logic [1:0]  kind;
    logic [23:0] n_frame;
    logic [7:0]  stride;
    logic [23:0] clocks_per_frame;
    logic [15:0] stop_after;        // reports before a stop, 0 = never
    logic        exp_error;
    logic        reset_after;
  } test_row_t;

  logic               CLK = 1'b0;
  logic               RESET;
  logic               pc_msg_valid;
  logic [XB_SIZE-1:0] pc_msg;
  logic               fpga_msg_valid;
  fpga_report_t       fpga_msg;
  logic               app_running;
  logic               app_error;
  logic [3:0]         gpio_led;

  test_row_t   rows [NUM_ROWS];
  string       names [NUM_ROWS];
  string       cur_name;
  logic [7:0]  cur_stride;
  int          rep_cnt;          // reports seen in the current row
  int          check_errors;
  int          timeout_errors;
  logic [31:0] lfsr_state;

  application dut_i (
    .CLK, .RESET, .pc_msg_valid, .pc_msg,
    .fpga_msg_valid, .fpga_msg, .app_running, .app_error, .gpio_led
  );

  always #10 CLK = ~CLK;

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic logic random_bit();
    lfsr_state = galois_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  task automatic check_value(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED: test %s, %s expected 0x%0h actual 0x%0h",
               cur_name, field, expected, actual);
      check_errors++;
    end
  endtask

  // i-th report of a run: frame i/128, zmw i mod 128, value zmw * stride
  always @(negedge CLK) begin
    if (RESET === 1'b0 && fpga_msg_valid === 1'b1) begin
      check_value("report frame", 32'((rep_cnt / N_ZMW) % 256), 32'(fpga_msg.frame));
      check_value("report zmw", 32'(rep_cnt % N_ZMW), 32'(fpga_msg.zmw));
      check_value("report value", 32'(((rep_cnt % N_ZMW) * int'(cur_stride)) % 65536),
                  32'(fpga_msg.value));
      rep_cnt++;
    end
  end

  task automatic load_table();
    names[0] = "idle_stop";
    rows[0]  = '{KIND_STOP, 24'd0, 8'd0, 24'd0, 16'd0, 1'b0, 1'b0};
    names[1] = "one_frame";
    rows[1]  = '{KIND_START, 24'd1, 8'd3, 24'd10, 16'd0, 1'b0, 1'b0};
    names[2] = "three_frames";
    rows[2]  = '{KIND_START, 24'd3, 8'd7, 24'd20, 16'd0, 1'b0, 1'b0};
    names[3] = "stop_run";
    rows[3]  = '{KIND_START, 24'd4, 8'd5, 24'd30, 16'd50, 1'b0, 1'b0};
    names[4] = "after_stop";
    rows[4]  = '{KIND_START, 24'd1, 8'd11, 24'd10, 16'd0, 1'b0, 1'b0};
    names[5] = "data_msg";
    rows[5]  = '{KIND_DATA, 24'd0, 8'd0, 24'd0, 16'd0, 1'b1, 1'b1};
    names[6] = "after_reset";
    rows[6]  = '{KIND_START, 24'd2, 8'd200, 24'd5, 16'd0, 1'b0, 1'b0};
  endtask

  task automatic send_word(input logic [XB_SIZE-1:0] word);
    int gaps;
    gaps = 0;
    while (gaps < 3 && random_bit()) begin  // random idle cycles
      @(posedge CLK);
      pc_msg_valid <= 1'b0;
      gaps++;
    end
    @(posedge CLK);
    pc_msg_valid <= 1'b1;
    pc_msg       <= word;
  endtask

  // word 0 is the header, word 1 the timing, word 2 the exposure
  task automatic send_cmd(input logic [1:0] kind, input logic [23:0] n_frame,
                          input logic [7:0] stride, input logic [23:0] clocks);
    logic [XB_SIZE-1:0] header;
    header = {n_frame, 1'b0, kind == KIND_START, 5'b0, kind == KIND_DATA};
    send_word(header);
    send_word({stride, clocks});
    send_word(32'hc0de_0000 | 32'(clocks[15:0]));
    @(posedge CLK);
    pc_msg_valid <= 1'b0;
  endtask

  task automatic wait_status(input bit use_error, input logic level);
    int   n;
    logic v;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
      v = use_error ? app_error : app_running;
    end while (v !== level && n < WAIT_LIMIT);
    if (v !== level) begin
      $display("TIMEOUT: test %s, %s did not reach %0d within %0d cycles", cur_name,
               use_error ? "app_error" : "app_running", level, WAIT_LIMIT);
      timeout_errors++;
    end
  endtask

  task automatic wait_reports(input int target);
    int n;
    n = 0;
    do begin
      @(posedge CLK);  // rep_cnt moves on the falling edge
      n++;
    end while (rep_cnt < target && n < WAIT_LIMIT);
    if (rep_cnt < target) begin
      $display("TIMEOUT: test %s, only %0d of %0d reports arrived within %0d cycles",
               cur_name, rep_cnt, target, WAIT_LIMIT);
      timeout_errors++;
    end
  endtask

  task automatic check_idle();
    check_value("idle fpga_msg_valid", 32'h0, 32'(fpga_msg_valid));
    check_value("idle app_running", 32'h0, 32'(app_running));
    check_value("idle app_error", 32'h0, 32'(app_error));
    check_value("idle gpio_led", 32'h1, 32'(gpio_led));
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    RESET        <= 1'b1;
    pc_msg_valid <= 1'b0;
    repeat (3) @(posedge CLK);
    RESET <= 1'b0;
    @(negedge CLK);
    rep_cnt = 0;
  endtask

  task automatic run_row(input int idx);
    test_row_t r;
    r          = rows[idx];
    cur_name   = names[idx];
    cur_stride = r.stride;
    rep_cnt    = 0;
    send_cmd(r.kind, r.n_frame, r.stride, r.clocks_per_frame);
    case (r.kind)
      KIND_START: begin
        wait_status(1'b0, 1'b1);
        if (r.stop_after != 0) begin
          wait_reports(int'(r.stop_after));
          send_cmd(KIND_STOP, 24'd0, 8'd0, 24'd0);  // stop mid frame
        end else begin
          wait_reports(int'(r.n_frame) * N_ZMW);
        end
        wait_status(1'b0, 1'b0);
        repeat (QUIET_CYCLES) @(negedge CLK);
        if (r.stop_after != 0) begin
          if (rep_cnt < int'(r.stop_after) || rep_cnt > N_ZMW + STOP_SLACK) begin
            $display("ERROR: test %s, %0d reports around the stop, allowed %0d to %0d",
                     cur_name, rep_cnt, r.stop_after, N_ZMW + STOP_SLACK);
            check_errors++;
          end
        end else begin
          check_value("report count", 32'(r.n_frame) * N_ZMW, 32'(rep_cnt));
        end
        check_value("gpio_led after run", 32'h1, 32'(gpio_led));
      end
      KIND_DATA: begin
        wait_status(1'b1, 1'b1);
        repeat (QUIET_CYCLES) @(negedge CLK);
        check_value("report count", 32'h0, 32'(rep_cnt));
        check_value("gpio_led in error", 32'h0, 32'(gpio_led));
        check_value("app_running in error", 32'h0, 32'(app_running));
      end
      default: begin  // stop while idle does nothing
        repeat (QUIET_CYCLES) @(negedge CLK);
        check_value("report count", 32'h0, 32'(rep_cnt));
        check_value("app_running", 32'h0, 32'(app_running));
      end
    endcase
    check_value("app_error", 32'(r.exp_error), 32'(app_error));
    if (r.reset_after) begin
      apply_reset();
      check_idle();
    end
  endtask

  initial begin
    RESET          = 1'b1;
    pc_msg_valid   = 1'b0;
    pc_msg         = '0;
    lfsr_state     = LFSR_SEED;
    rep_cnt        = 0;
    check_errors   = 0;
    timeout_errors = 0;
    cur_name       = "reset";
    cur_stride     = '0;
    load_table();
    repeat (3) @(posedge CLK);
    RESET <= 1'b0;
    @(negedge CLK);
    check_idle();
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("summary: %0d check errors, %0d timeouts", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/host_msg_pkg.sv
design/pulse_ram_pkg.sv
design/token_fifo.sv
design/pulse_list_bram.sv
design/msg_assembler.sv
design/frame_pacer.sv
design/pulse_list_ram_ctrl.sv
design/application.sv
tb/tb_application.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_application \
  --Mdir obj_dir -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 &&
grep -q "RESULT: PASS" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
